//--- mem_system.f
common/mem_sys_pkg.sv
cache/cache_array.sv
cache/cache_ctrl.sv
memory/mem_bank.sv
memory/four_bank_mem.sv
verilog/mem_system.sv
bench/mem_system_tb.sv

//--- Bender.yml
package:
  name: mem_system

sources:
  - common/mem_sys_pkg.sv
  - cache/cache_array.sv
  - cache/cache_ctrl.sv
  - memory/mem_bank.sv
  - memory/four_bank_mem.sv
  - verilog/mem_system.sv
  - target: test
    files:
      - bench/mem_system_tb.sv

//--- bench/mem_system_tb.sv
//##########################################################################
// Random-stimulus testbench with reference memory and cache tag model
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module mem_system_tb;
   import mem_sys_pkg::*;

   // Request count over all tests sets the cycle budget
   localparam int NUM_REQ    = 8 + 2 + 3 + 300 + 12;
   localparam int MAX_CYCLES = 200 * NUM_REQ;

   logic              clk;
   logic              rst_n;
   logic [ADDR_W-1:0] Addr;
   logic [DATA_W-1:0] DataIn;
   logic              Rd;
   logic              Wr;
   logic [DATA_W-1:0] DataOut;
   logic              Done;
   logic              Stall;
   logic              CacheHit;
   logic              err;

   logic [DATA_W-1:0] ref_mem [1 << (ADDR_W - 1)];
   logic [TAG_W-1:0]  model_tag [NUM_LINES];
   logic [NUM_LINES-1:0] model_valid;
   logic [31:0]       lfsr_state;
   int                cycle_cnt;
   int                pass_cnt;
   int                fail_cnt;
   int                fail_base;

   mem_system mem_system_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: run exceeded %0d cycles before all requests completed", MAX_CYCLES);
         $display("TB FAILED");
         $finish;
      end
   end

   // Taps x^32 + x^22 + x^2 + x + 1 with one step per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) begin
         pass_cnt++;
      end else begin
         $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
         fail_cnt++;
      end
   endtask

   task automatic report_test(input int num, input string name);
      if (fail_cnt == fail_base) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, fail_cnt - fail_base);
      end
      fail_base = fail_cnt;
   endtask

   // One request pulse, then wait for Done at falling edges
   task automatic access(input logic is_wr, input logic [15:0] a, input logic [15:0] d,
                         output int lat, output logic stall_first);
      @(posedge clk);
      Addr   <= a;
      DataIn <= d;
      Rd     <= !is_wr;
      Wr     <= is_wr;
      @(posedge clk);
      Rd <= 1'b0;
      Wr <= 1'b0;
      @(negedge clk);
      lat = 1;
      stall_first = Stall;
      while (!Done) begin
         @(negedge clk);
         lat++;
      end
   endtask

   task automatic checked_access(input logic is_wr, input logic [15:0] a, input logic [15:0] d);
      logic [INDEX_W-1:0] idx;
      logic [TAG_W-1:0]   tg;
      logic               exp_hit;
      logic [DATA_W-1:0]  exp_data;
      logic               stall_first;
      int                 lat;
      idx      = a[10:3];
      tg       = a[15:11];
      exp_hit  = model_valid[idx] && (model_tag[idx] == tg);
      exp_data = ref_mem[a[15:1]];
      access(is_wr, a, d, lat, stall_first);
      check_val("err", err, 1'b0);
      check_val("CacheHit", CacheHit, exp_hit);
      check_val("Stall", stall_first, !exp_hit);
      if (exp_hit) begin
         check_val("Done latency", lat, 1);
      end
      if (is_wr) begin
         ref_mem[a[15:1]] = d;
      end else begin
         check_val("DataOut", DataOut, exp_data);
      end
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tg;
   endtask

   task automatic odd_access(input logic is_wr, input logic [15:0] a, input logic [15:0] d);
      int   lat;
      logic stall_first;
      access(is_wr, a, d, lat, stall_first);
      check_val("Done latency", lat, 1);
      check_val("Stall", stall_first, 1'b0);
      check_val("err", err, 1'b1);
      check_val("CacheHit", CacheHit, 1'b0);
   endtask

   initial begin
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] d;
      logic [1:0]  tg;
      logic [2:0]  idx;
      logic [1:0]  w;
      logic        is_wr;
      rst_n      = 1'b0;
      Addr       = '0;
      DataIn     = '0;
      Rd         = 1'b0;
      Wr         = 1'b0;
      cycle_cnt  = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      fail_base  = 0;
      lfsr_state = 32'h8eb5_d873;
      model_valid = '0;
      for (int i = 0; i < (1 << (ADDR_W - 1)); i++) begin
         ref_mem[i] = '0;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_val("Done", Done, 1'b0);
      check_val("Stall", Stall, 1'b0);
      check_val("CacheHit", CacheHit, 1'b0);
      check_val("err", err, 1'b0);

      // First touch of fresh lines reads zero
      for (int i = 0; i < 8; i++) begin
         a = {5'h1f, 8'(8'h80 + i * 3), 2'(i), 1'b0};
         checked_access(1'b0, a, 16'h0);
      end
      report_test(1, "cold reads");

      a = {5'd2, 8'h20, 2'd1, 1'b0};
      checked_access(1'b1, a, 16'(lfsr_bits(16)));
      checked_access(1'b0, a, 16'h0);
      report_test(2, "write then read hit");

      // Same index, different tag forces a dirty eviction
      a = {5'd5, 8'h40, 2'd2, 1'b0};
      b = {5'd9, 8'h40, 2'd2, 1'b0};
      checked_access(1'b1, a, 16'(lfsr_bits(16)));
      checked_access(1'b1, b, 16'(lfsr_bits(16)));
      checked_access(1'b0, a, 16'h0);
      report_test(3, "dirty write-back");

      for (int n = 0; n < 300; n++) begin
         is_wr = lfsr_bits(1);
         tg    = lfsr_bits(2);
         idx   = lfsr_bits(3);
         w     = lfsr_bits(2);
         d     = lfsr_bits(16);
         a     = {3'b000, tg, 5'b00000, idx, w, 1'b0};
         checked_access(is_wr, a, d);
      end
      report_test(4, "random stream");

      // Target lines resident so a stray odd write would hit them
      for (int i = 0; i < 4; i++) begin
         a = {5'd1, 8'(i), 2'(i), 1'b0};
         checked_access(1'b0, a, 16'h0);
      end
      for (int i = 0; i < 4; i++) begin
         a = {5'd1, 8'(i), 2'(i), 1'b1};
         odd_access(i % 2 == 0, a, 16'(lfsr_bits(16)));
      end
      for (int i = 0; i < 4; i++) begin
         a = {5'd1, 8'(i), 2'(i), 1'b0};
         checked_access(1'b0, a, 16'h0);
      end
      report_test(5, "misaligned access");

      $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/mem_system.sv
//##########################################################################
// Memory system top: cache controller, cache array, banked memory
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module mem_system (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_sys_pkg::ADDR_W-1:0] Addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] DataIn,
   input  logic                           Rd,
   input  logic                           Wr,
   output logic [mem_sys_pkg::DATA_W-1:0] DataOut,
   output logic                           Done,
   output logic                           Stall,
   output logic                           CacheHit,
   output logic                           err
);
   import mem_sys_pkg::*;

   logic                cache_en, cache_wr, comp, valid_in;
   logic                hit, dirty, valid;
   logic [TAG_W-1:0]    cache_tag, tag_out;
   logic [INDEX_W-1:0]  cache_index;
   logic [OFFSET_W-1:0] offset;
   logic [DATA_W-1:0]   cache_data_in, cache_data_out;
   logic [ADDR_W-1:0]   mem_addr;
   logic [DATA_W-1:0]   mem_data_in, mem_data_out;
   logic                mem_wr, mem_rd, mem_stall;

   cache_ctrl ctrl_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .addr          (Addr),
      .data          (DataIn),
      .rd            (Rd),
      .wr            (Wr),
      .hit           (hit),
      .dirty         (dirty),
      .valid         (valid),
      .tag_out       (tag_out),
      .cache_data    (cache_data_out),
      .mem_data      (mem_data_out),
      .mem_stall     (mem_stall),
      .cache_en      (cache_en),
      .cache_tag     (cache_tag),
      .cache_index   (cache_index),
      .offset        (offset),
      .cache_data_in (cache_data_in),
      .cache_wr      (cache_wr),
      .comp          (comp),
      .valid_in      (valid_in),
      .mem_addr      (mem_addr),
      .mem_wr        (mem_wr),
      .mem_rd        (mem_rd),
      .mem_data_out  (mem_data_in),
      .data_out      (DataOut),
      .done          (Done),
      .stall         (Stall),
      .cache_hit     (CacheHit),
      .err           (err)
   );

   cache_array cache_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (cache_en),
      .tag_in   (cache_tag),
      .index    (cache_index),
      .offset   (offset),
      .data_in  (cache_data_in),
      .comp     (comp),
      .write    (cache_wr),
      .valid_in (valid_in),
      .tag_out  (tag_out),
      .data_out (cache_data_out),
      .hit      (hit),
      .dirty    (dirty),
      .valid    (valid)
   );

   // Per-bank busy is not needed by the controller, stall covers it
   four_bank_mem mem_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .addr     (mem_addr),
      .data_in  (mem_data_in),
      .wr       (mem_wr),
      .rd       (mem_rd),
      .data_out (mem_data_out),
      .stall    (mem_stall),
      .busy     ()
   );

endmodule

`default_nettype wire

//--- memory/four_bank_mem.sv
//##########################################################################
// Four interleaved memory banks with per-bank busy and stall
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module four_bank_mem (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [mem_sys_pkg::ADDR_W-1:0]    addr,
   input  logic [mem_sys_pkg::DATA_W-1:0]    data_in,
   input  logic                              wr,
   input  logic                              rd,
   output logic [mem_sys_pkg::DATA_W-1:0]    data_out,
   output logic                              stall,
   output logic [mem_sys_pkg::NUM_BANKS-1:0] busy
);
   import mem_sys_pkg::*;

   logic [BANK_SEL_W-1:0]  bank;
   logic [BANK_ADDR_W-1:0] word_addr;
   logic [DATA_W-1:0]      bank_data [NUM_BANKS];
   // Bank id of each in-flight read, aligned with its data
   logic [BANK_SEL_W-1:0]  rd_bank [MEM_RD_LAT+1];

   // Word-interleaved: bits 2:1 pick the bank, upper bits the row
   assign bank      = addr[1 +: BANK_SEL_W];
   assign word_addr = addr[ADDR_W-1 -: BANK_ADDR_W];
   assign stall     = (rd | wr) & busy[bank];
   assign data_out  = bank_data[rd_bank[MEM_RD_LAT]];

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      logic sel;

      assign sel = (bank == BANK_SEL_W'(i)) & ~busy[i];

      mem_bank bank_inst (
         .clk       (clk),
         .rst_n     (rst_n),
         .word_addr (word_addr),
         .data_in   (data_in),
         .wr        (wr & sel),
         .rd        (rd & sel),
         .data_out  (bank_data[i]),
         .busy      (busy[i])
      );
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i <= MEM_RD_LAT; i++) begin
            rd_bank[i] <= '0;
         end
      end else begin
         if (rd && !stall) begin
            rd_bank[0] <= bank;
         end
         for (int i = 1; i <= MEM_RD_LAT; i++) begin
            rd_bank[i] <= rd_bank[i-1];
         end
      end
   end

endmodule

`default_nettype wire

//--- memory/mem_bank.sv
//##########################################################################
// One memory bank with fixed read latency and busy window
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module mem_bank (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [mem_sys_pkg::BANK_ADDR_W-1:0] word_addr,
   input  logic [mem_sys_pkg::DATA_W-1:0]      data_in,
   input  logic                                wr,
   input  logic                                rd,
   output logic [mem_sys_pkg::DATA_W-1:0]      data_out,
   output logic                                busy
);
   import mem_sys_pkg::*;

   logic [DATA_W-1:0]      mem [BANK_WORDS];
   logic [DATA_W-1:0]      rd_pipe [MEM_RD_LAT];
   logic [BANK_ADDR_W-1:0] rd_addr;
   logic [BUSY_CNT_W-1:0]  busy_cnt;
   logic                   accept;

   assign accept   = (rd | wr) & ~busy;
   assign busy     = busy_cnt != '0;
   assign data_out = rd_pipe[MEM_RD_LAT-1];

   initial begin
      for (int i = 0; i < BANK_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_cnt <= '0;
      end else if (accept) begin
         busy_cnt <= BUSY_CNT_W'(BANK_BUSY_CYCLES);
      end else if (busy) begin
         busy_cnt <= busy_cnt - 1'b1;
      end
   end

   // Array read one cycle after acceptance, then the delay stages
   always_ff @(posedge clk) begin
      if (wr && accept) begin
         mem[word_addr] <= data_in;
      end
      if (rd && accept) begin
         rd_addr <= word_addr;
      end
      rd_pipe[0] <= mem[rd_addr];
      for (int i = 1; i < MEM_RD_LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

endmodule

`default_nettype wire

//--- cache/cache_ctrl.sv
//##########################################################################
// Cache controller FSM: hits, dirty write-back, line fill, final access
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [mem_sys_pkg::ADDR_W-1:0]   addr,
   input  logic [mem_sys_pkg::DATA_W-1:0]   data,
   input  logic                             rd,
   input  logic                             wr,
   input  logic                             hit,
   input  logic                             dirty,
   input  logic                             valid,
   input  logic [mem_sys_pkg::TAG_W-1:0]    tag_out,
   input  logic [mem_sys_pkg::DATA_W-1:0]   cache_data,
   input  logic [mem_sys_pkg::DATA_W-1:0]   mem_data,
   input  logic                             mem_stall,
   output logic                             cache_en,
   output logic [mem_sys_pkg::TAG_W-1:0]    cache_tag,
   output logic [mem_sys_pkg::INDEX_W-1:0]  cache_index,
   output logic [mem_sys_pkg::OFFSET_W-1:0] offset,
   output logic [mem_sys_pkg::DATA_W-1:0]   cache_data_in,
   output logic                             cache_wr,
   output logic                             comp,
   output logic                             valid_in,
   output logic [mem_sys_pkg::ADDR_W-1:0]   mem_addr,
   output logic                             mem_wr,
   output logic                             mem_rd,
   output logic [mem_sys_pkg::DATA_W-1:0]   mem_data_out,
   output logic [mem_sys_pkg::DATA_W-1:0]   data_out,
   output logic                             done,
   output logic                             stall,
   output logic                             cache_hit,
   output logic                             err
);
   import mem_sys_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_COMPARE,
      S_WB,
      S_FILL_ISSUE,
      S_FILL_WAIT,
      S_FINAL
   } state_t;

   state_t                state;
   logic [ADDR_W-1:0]     req_addr;
   logic [DATA_W-1:0]     req_data;
   logic                  req_wr;
   logic [WORD_SEL_W-1:0] issue_cnt;
   logic [WORD_SEL_W-1:0] ret_cnt;
   logic [MEM_RD_LAT:0]   rd_inflight;
   logic                  accept;
   logic                  aligned;
   logic                  mem_go;
   logic                  word_ret;
   logic                  issue_last;
   logic                  ret_last;

   // New request only while idle and not finishing the previous one
   assign accept     = (state == S_IDLE) && (rd || wr) && !done;
   assign aligned    = !addr[0];
   assign mem_go     = !mem_stall;
   assign word_ret   = rd_inflight[MEM_RD_LAT];
   assign issue_last = issue_cnt == WORD_SEL_W'(WORDS_PER_LINE - 1);
   assign ret_last   = ret_cnt == WORD_SEL_W'(WORDS_PER_LINE - 1);

   // Victim words go straight from the array to memory
   assign mem_data_out = cache_data;

   always_comb begin
      cache_en      = 1'b0;
      cache_tag     = req_addr[ADDR_W-1 -: TAG_W];
      cache_index   = req_addr[OFFSET_W +: INDEX_W];
      offset        = req_addr[OFFSET_W-1:0];
      cache_data_in = req_data;
      cache_wr      = 1'b0;
      comp          = 1'b1;
      valid_in      = 1'b1;
      mem_addr      = {req_addr[ADDR_W-1:OFFSET_W], issue_cnt, 1'b0};
      mem_wr        = 1'b0;
      mem_rd        = 1'b0;
      case (state)
         S_IDLE: begin
            // Compare against the incoming request for a one-cycle hit
            cache_en      = accept && aligned;
            cache_tag     = addr[ADDR_W-1 -: TAG_W];
            cache_index   = addr[OFFSET_W +: INDEX_W];
            offset        = addr[OFFSET_W-1:0];
            cache_data_in = data;
            cache_wr      = accept && aligned && wr;
         end
         S_COMPARE: begin
            cache_en = 1'b1;
         end
         S_WB: begin
            cache_en = 1'b1;
            comp     = 1'b0;
            offset   = {issue_cnt, 1'b0};
            mem_addr = {tag_out, req_addr[OFFSET_W +: INDEX_W], issue_cnt, 1'b0};
            mem_wr   = 1'b1;
         end
         S_FILL_ISSUE, S_FILL_WAIT: begin
            mem_rd        = state == S_FILL_ISSUE;
            cache_en      = word_ret;
            cache_wr      = word_ret;
            comp          = 1'b0;
            offset        = {ret_cnt, 1'b0};
            cache_data_in = mem_data;
         end
         S_FINAL: begin
            cache_en = 1'b1;
            cache_wr = req_wr;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= S_IDLE;
         issue_cnt   <= '0;
         ret_cnt     <= '0;
         rd_inflight <= '0;
         done        <= 1'b0;
         stall       <= 1'b0;
         cache_hit   <= 1'b0;
         err         <= 1'b0;
      end else begin
         done        <= 1'b0;
         cache_hit   <= 1'b0;
         err         <= 1'b0;
         // Marks each accepted fill read until its data comes back
         rd_inflight <= {rd_inflight[MEM_RD_LAT-1:0], mem_rd & mem_go};
         case (state)
            S_IDLE: begin
               if (accept) begin
                  if (!aligned) begin
                     done <= 1'b1;
                     err  <= 1'b1;
                  end else if (hit) begin
                     done      <= 1'b1;
                     cache_hit <= 1'b1;
                  end else begin
                     stall <= 1'b1;
                     state <= S_COMPARE;
                  end
               end
            end
            S_COMPARE: begin
               state <= (valid && dirty) ? S_WB : S_FILL_ISSUE;
            end
            S_WB: begin
               if (mem_go) begin
                  issue_cnt <= issue_cnt + 1'b1;
                  if (issue_last) begin
                     state <= S_FILL_ISSUE;
                  end
               end
            end
            S_FILL_ISSUE, S_FILL_WAIT: begin
               if (mem_rd && mem_go) begin
                  issue_cnt <= issue_cnt + 1'b1;
                  if (issue_last) begin
                     state <= S_FILL_WAIT;
                  end
               end
               if (word_ret) begin
                  ret_cnt <= ret_cnt + 1'b1;
                  if (ret_last) begin
                     state <= S_FINAL;
                  end
               end
            end
            S_FINAL: begin
               done  <= 1'b1;
               stall <= 1'b0;
               state <= S_IDLE;
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // Request latch and read data
   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data;
         req_wr   <= wr;
      end
      if ((accept && aligned) || state == S_FINAL) begin
         data_out <= cache_data;
      end
   end

endmodule

`default_nettype wire

//--- cache/cache_array.sv
//##########################################################################
// Direct-mapped cache storage: tag, valid, dirty and line data
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module cache_array (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             enable,
   input  logic [mem_sys_pkg::TAG_W-1:0]    tag_in,
   input  logic [mem_sys_pkg::INDEX_W-1:0]  index,
   input  logic [mem_sys_pkg::OFFSET_W-1:0] offset,
   input  logic [mem_sys_pkg::DATA_W-1:0]   data_in,
   input  logic                             comp,
   input  logic                             write,
   input  logic                             valid_in,
   output logic [mem_sys_pkg::TAG_W-1:0]    tag_out,
   output logic [mem_sys_pkg::DATA_W-1:0]   data_out,
   output logic                             hit,
   output logic                             dirty,
   output logic                             valid
);
   import mem_sys_pkg::*;

   logic [TAG_W-1:0]      tag_mem  [NUM_LINES];
   logic [DATA_W-1:0]     data_mem [NUM_LINES][WORDS_PER_LINE];
   logic [NUM_LINES-1:0]  valid_bits;
   logic [NUM_LINES-1:0]  dirty_bits;
   logic [WORD_SEL_W-1:0] word;
   logic                  fill;
   logic                  do_write;

   // Byte offset bit 0 is never used, words are 16 bits
   assign word = offset[OFFSET_W-1:1];

   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[index][word];
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign hit      = valid & (tag_out == tag_in);

   // Fill writes unconditionally, compare-write only on a hit
   assign fill     = enable & write & ~comp;
   assign do_write = enable & write & (~comp | hit);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (do_write) begin
         // Processor write marks dirty, line fill leaves it clean
         dirty_bits[index] <= comp;
         if (fill) begin
            valid_bits[index] <= valid_in;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         data_mem[index][word] <= data_in;
      end
      if (fill) begin
         tag_mem[index] <= tag_in;
      end
   end

endmodule

`default_nettype wire

//--- common/mem_sys_pkg.sv
//##########################################################################
// Address fields, cache line geometry and banked memory timing
//##########################################################################

`default_nettype none

package mem_sys_pkg;

   // Processor address and data
   localparam int ADDR_W   = 16;
   localparam int DATA_W   = 16;

   // Address split: tag | index | byte offset
   localparam int TAG_W    = 5;
   localparam int INDEX_W  = 8;
   localparam int OFFSET_W = 3;

   // Cache geometry
   localparam int NUM_LINES      = 1 << INDEX_W;
   localparam int WORDS_PER_LINE = 4;
   localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);

   // Banked main memory, bank picked by address bits 2:1
   localparam int NUM_BANKS   = 4;
   localparam int BANK_SEL_W  = $clog2(NUM_BANKS);
   localparam int BANK_WORDS  = 8192;
   localparam int BANK_ADDR_W = $clog2(BANK_WORDS);

   // Bank timing
   localparam int MEM_RD_LAT       = 2;
   localparam int BANK_BUSY_CYCLES = 4;
   localparam int BUSY_CNT_W       = $clog2(BANK_BUSY_CYCLES + 1);

endpackage

`default_nettype wire
